/* logic/axi_config.svh */
`ifndef AXI_CONFIG_SVH
`define AXI_CONFIG_SVH

// Word width shared by the register bus and the stream
`define AXI_DWIDTH 32

// One strobe bit per byte lane
`define AXI_STRB_WIDTH (`AXI_DWIDTH / 8)

// Byte address into the four-register map
`define AXI_AWIDTH 4

// AXI protection field width
`define AXI_PROT_WIDTH 3

// Capture buffer size, kept a power of two
`define BUF_DEPTH_LOG2 4
`define BUF_DEPTH (1 << `BUF_DEPTH_LOG2)

`endif

/* logic/axi_pkg.sv */
`default_nettype none

`include "axi_config.svh"

package axi_pkg;

  // Control register, seen as a plain word or as its fields
  typedef union packed {
    logic [`AXI_DWIDTH-1:0] raw;          // Word as written and read back
    struct packed {
      logic [`AXI_DWIDTH-3:0] reserved;   // Stored, no function
      logic                   flush;      // Self-clearing buffer flush
      logic                   stream_enable; // Opens the stream slave
    } f;
  } ctrl_word_u;

  // Register map, byte offsets
  localparam logic [`AXI_AWIDTH-1:0] REG_CTRL    = 'h0;
  localparam logic [`AXI_AWIDTH-1:0] REG_SCRATCH = 'h4;
  localparam logic [`AXI_AWIDTH-1:0] REG_STATUS  = 'h8; // Read only
  localparam logic [`AXI_AWIDTH-1:0] REG_DATA    = 'hC; // Read pops the buffer

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Status word layout
  localparam int STAT_EMPTY_BIT = 0;
  localparam int STAT_FULL_BIT  = 1;
  localparam int STAT_COUNT_LSB = 8;                   // Occupancy field base
  localparam int STAT_COUNT_W   = `BUF_DEPTH_LOG2 + 1; // Holds 0 up to depth

endpackage

`default_nettype wire

/* logic/axi_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_config.svh"

module axi_top (
  input  wire                          aclk,
  input  wire                          rst,
  // AXI-Lite register slave
  input  wire [`AXI_AWIDTH-1:0]        s_axi_lite_awaddr,
  input  wire [`AXI_PROT_WIDTH-1:0]    s_axi_lite_awprot,   // Not decoded
  input  wire                          s_axi_lite_awvalid,
  output wire                          s_axi_lite_awready,
  input  wire [`AXI_DWIDTH-1:0]        s_axi_lite_wdata,
  input  wire [`AXI_STRB_WIDTH-1:0]    s_axi_lite_wstrb,    // Full-word writes only
  input  wire                          s_axi_lite_wvalid,
  output wire                          s_axi_lite_wready,
  output wire [1:0]                    s_axi_lite_bresp,
  output wire                          s_axi_lite_bvalid,
  input  wire                          s_axi_lite_bready,
  input  wire [`AXI_AWIDTH-1:0]        s_axi_lite_araddr,
  input  wire [`AXI_PROT_WIDTH-1:0]    s_axi_lite_arprot,   // Not decoded
  input  wire                          s_axi_lite_arvalid,
  output wire                          s_axi_lite_arready,
  output wire [`AXI_DWIDTH-1:0]        s_axi_lite_rdata,
  output wire [1:0]                    s_axi_lite_rresp,
  output wire                          s_axi_lite_rvalid,
  input  wire                          s_axi_lite_rready,
  // AXI stream slave
  input  wire [`AXI_DWIDTH-1:0]        s_axi_stream_tdata,
  input  wire [`AXI_STRB_WIDTH-1:0]    s_axi_stream_tstrb,  // Buffer keeps tdata only
  input  wire                          s_axi_stream_tlast,  // No packet framing
  input  wire                          s_axi_stream_tvalid,
  output wire                          s_axi_stream_tready
);

  import axi_pkg::*;

  wire ctrl_word_u              ctrl_word;  // Enable for the stream side
  wire [`AXI_DWIDTH-1:0]        scratch;
  wire                          flush;
  wire                          buf_pop;    // DATA read consumed the head
  wire [`AXI_DWIDTH-1:0]        buf_head;
  wire [`BUF_DEPTH_LOG2:0]      buf_count;
  wire                          buf_empty;
  wire                          buf_full;

  lite_write u_lite_write (
    .aclk      (aclk),
    .rst       (rst),
    .awaddr    (s_axi_lite_awaddr),
    .awvalid   (s_axi_lite_awvalid),
    .awready   (s_axi_lite_awready),
    .wdata     (s_axi_lite_wdata),
    .wvalid    (s_axi_lite_wvalid),
    .wready    (s_axi_lite_wready),
    .bvalid    (s_axi_lite_bvalid),
    .bresp     (s_axi_lite_bresp),
    .bready    (s_axi_lite_bready),
    .ctrl_word (ctrl_word),
    .scratch   (scratch),
    .flush     (flush)
  );

  lite_read u_lite_read (
    .aclk      (aclk),
    .rst       (rst),
    .araddr    (s_axi_lite_araddr),
    .arvalid   (s_axi_lite_arvalid),
    .arready   (s_axi_lite_arready),
    .rvalid    (s_axi_lite_rvalid),
    .rdata     (s_axi_lite_rdata),
    .rresp     (s_axi_lite_rresp),
    .rready    (s_axi_lite_rready),
    .ctrl_word (ctrl_word),
    .scratch   (scratch),
    .buf_head  (buf_head),
    .buf_count (buf_count),
    .buf_empty (buf_empty),
    .buf_full  (buf_full),
    .buf_pop   (buf_pop)
  );

  stream_buffer u_stream_buffer (
    .aclk          (aclk),
    .rst           (rst),
    .tdata         (s_axi_stream_tdata),
    .tvalid        (s_axi_stream_tvalid),
    .tready        (s_axi_stream_tready),
    .stream_enable (ctrl_word.f.stream_enable), // Field view of CTRL
    .buf_pop       (buf_pop),
    .flush         (flush),
    .buf_head      (buf_head),
    .buf_count     (buf_count),
    .buf_empty     (buf_empty),
    .buf_full      (buf_full)
  );

endmodule

`default_nettype wire

/* logic/lite_read.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_config.svh"

module lite_read (
  input  wire                       aclk,
  input  wire                       rst,
  input  wire [`AXI_AWIDTH-1:0]     araddr,
  input  wire                       arvalid,
  output logic                      arready,
  output logic                      rvalid,
  output logic [`AXI_DWIDTH-1:0]    rdata,
  output logic [1:0]                rresp,
  input  wire                       rready,
  input  wire axi_pkg::ctrl_word_u  ctrl_word,
  input  wire [`AXI_DWIDTH-1:0]     scratch,
  input  wire [`AXI_DWIDTH-1:0]     buf_head,
  input  wire [`BUF_DEPTH_LOG2:0]   buf_count,
  input  wire                       buf_empty,
  input  wire                       buf_full,
  output logic                      buf_pop      // Head consumed this cycle
);

  import axi_pkg::*;

  logic                   rd_accept;   // Address taken this cycle
  logic [`AXI_DWIDTH-1:0] status_word;
  logic [`AXI_DWIDTH-1:0] rd_word;     // Selected read data
  logic [1:0]             rd_resp;

  assign rd_accept = arready & arvalid;

  // Status assembly
  always_comb begin
    status_word                                  = '0;
    status_word[STAT_EMPTY_BIT]                  = buf_empty;
    status_word[STAT_FULL_BIT]                   = buf_full;
    status_word[STAT_COUNT_LSB +: STAT_COUNT_W]  = buf_count;
  end

  // Address decode and read mux
  always_comb begin
    rd_word = '0;
    rd_resp = RESP_OKAY;
    case (araddr)
      REG_CTRL:    rd_word = ctrl_word.raw;
      REG_SCRATCH: rd_word = scratch;
      REG_STATUS:  rd_word = status_word;
      REG_DATA: begin
        if (buf_empty) begin
          rd_resp = RESP_SLVERR;   // Nothing to hand out
        end else begin
          rd_word = buf_head;
        end
      end
      default:     rd_resp = RESP_SLVERR; // Unmapped offset
    endcase
  end

  // DATA read pops in the accept cycle and never on empty
  assign buf_pop = rd_accept & (araddr == REG_DATA) & ~buf_empty;

  // Address ready for one cycle while no data waits
  always_ff @(posedge aclk) begin
    if (rst) begin
      arready <= 1'b0;
    end else begin
      arready <= arvalid & ~rvalid & ~arready;
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      rvalid <= 1'b0;
    end else if (rd_accept) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // Data captured at accept and held through back-pressure
  always_ff @(posedge aclk) begin
    if (rd_accept) begin
      rdata <= rd_word;
      rresp <= rd_resp;
    end
  end

  // A pop always goes with a DATA read that found data
  a_pop_not_empty: assert property (
    @(posedge aclk) disable iff (rst)
    buf_pop |=> rvalid && (rresp == RESP_OKAY)
  ) else $error("pop issued without a data response");

  a_rdata_stable: assert property (
    @(posedge aclk) disable iff (rst)
    rvalid && !rready |=> $stable(rdata)
  ) else $error("rdata changed while stalled");

endmodule

`default_nettype wire

/* logic/lite_write.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_config.svh"

module lite_write (
  input  wire                       aclk,
  input  wire                       rst,
  input  wire [`AXI_AWIDTH-1:0]     awaddr,
  input  wire                       awvalid,
  output logic                      awready,
  input  wire [`AXI_DWIDTH-1:0]     wdata,
  input  wire                       wvalid,
  output logic                      wready,
  output logic                      bvalid,
  output logic [1:0]                bresp,
  input  wire                       bready,
  output axi_pkg::ctrl_word_u       ctrl_word, // Stored control with flush reading 0
  output logic [`AXI_DWIDTH-1:0]    scratch,
  output logic                      flush      // Pulse after a CTRL write
);

  import axi_pkg::*;

  logic       wr_rdy;      // Shared address and data ready
  logic       wr_accept;   // Address and data taken this cycle
  logic       hit_ctrl;
  logic       hit_scratch;
  ctrl_word_u wdata_u;     // Write data in control layout

  assign wdata_u.raw = wdata;

  assign awready = wr_rdy;
  assign wready  = wr_rdy; // Both channels taken together

  assign wr_accept   = wr_rdy & awvalid & wvalid;
  assign hit_ctrl    = (awaddr == REG_CTRL);
  assign hit_scratch = (awaddr == REG_SCRATCH);

  // Ready for one cycle once both valids are up and no response waits
  always_ff @(posedge aclk) begin
    if (rst) begin
      wr_rdy <= 1'b0;
    end else begin
      wr_rdy <= awvalid & wvalid & ~bvalid & ~wr_rdy;
    end
  end

  // Write response
  always_ff @(posedge aclk) begin
    if (rst) begin
      bvalid <= 1'b0;
    end else if (wr_accept) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;              // Held until the master takes it
    end
  end

  always_ff @(posedge aclk) begin
    if (wr_accept) begin
      bresp <= (hit_ctrl | hit_scratch) ? RESP_OKAY : RESP_SLVERR; // Others read only
    end
  end

  // Register file
  always_ff @(posedge aclk) begin
    if (rst) begin
      ctrl_word <= '0;             // Stream disabled out of reset
      scratch   <= '0;
      flush     <= 1'b0;
    end else begin
      flush <= wr_accept & hit_ctrl & wdata_u.f.flush; // Single-cycle strobe
      if (wr_accept & hit_ctrl) begin
        ctrl_word         <= wdata_u;
        ctrl_word.f.flush <= 1'b0;  // Flush bit never stored
      end
      if (wr_accept & hit_scratch) begin
        scratch <= wdata;
      end
    end
  end

  // No write taken in any cycle where a response is still held
  a_no_accept_in_resp: assert property (
    @(posedge aclk) disable iff (rst)
    bvalid |-> !wready
  ) else $error("wready raised with a response pending");

  // Flush reaches the buffer as a single pulse
  a_flush_pulse: assert property (
    @(posedge aclk) disable iff (rst)
    flush |=> !flush
  ) else $error("flush held for two cycles");

endmodule

`default_nettype wire

/* logic/stream_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_config.svh"

module stream_buffer (
  input  wire                       aclk,
  input  wire                       rst,
  input  wire [`AXI_DWIDTH-1:0]     tdata,         // Stream payload
  input  wire                       tvalid,
  output logic                      tready,
  input  wire                       stream_enable, // From the control register
  input  wire                       buf_pop,       // Head consumed by a DATA read
  input  wire                       flush,         // One-cycle clear request
  output logic [`AXI_DWIDTH-1:0]    buf_head,      // Oldest stored word
  output logic [`BUF_DEPTH_LOG2:0]  buf_count,
  output logic                      buf_empty,
  output logic                      buf_full
);

  localparam int unsigned AW    = `BUF_DEPTH_LOG2; // Pointer width
  localparam int unsigned DEPTH = `BUF_DEPTH;

  logic [`AXI_DWIDTH-1:0] mem [DEPTH]; // Word storage
  logic [AW-1:0]          wr_ptr;      // Next free slot
  logic [AW-1:0]          rd_ptr;      // Head slot
  logic [AW:0]            count;       // One extra bit to tell full from empty
  logic                   push;
  logic                   pop;

  // Stream side handshake
  assign tready = stream_enable & ~buf_full;   // Stall source when off or full
  assign push   = tvalid & tready;             // Beat accepted this cycle
  assign pop    = buf_pop & ~buf_empty;        // Never step past the tail

  // Occupancy flags
  assign buf_empty = (count == '0);
  assign buf_full  = (count == (AW + 1)'(DEPTH));
  assign buf_count = count;

  assign buf_head = mem[rd_ptr]; // Head visible without a read cycle

  // Storage write
  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= tdata;
    end
  end

  // Pointers and count
  always_ff @(posedge aclk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin // Drops the whole content and any push now
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1; // Wraps at depth
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;   // Idle or push with pop
      endcase
    end
  end

  // Occupancy bound, covering the pop path from the read channel
  a_count_bound: assert property (
    @(posedge aclk) disable iff (rst)
    buf_count <= (AW + 1)'(DEPTH)
  ) else $error("buffer count above depth");

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the result from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_axi_top -f vlog.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx "TESTBENCH PASSED" sim.log && echo "result: pass" \
  || { echo "result: fail"; exit 1; }

/* test/tb_axi_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_config.svh"

module tb_axi_top;

  import axi_pkg::*;

  localparam int DRIVE_DLY   = 10;                  // Input skew after rising edge
  localparam int TEST_CYCLES = 1200;                // Rough length of the six tests
  localparam int MAX_CYCLES  = TEST_CYCLES * 5 / 2; // Margin over the test length
  localparam int DEPTH       = `BUF_DEPTH;

  logic                         aclk = 1'b0;
  logic                         rst;
  logic [`AXI_AWIDTH-1:0]       awaddr;
  logic [`AXI_PROT_WIDTH-1:0]   awprot;
  logic                         awvalid;
  logic                         awready;
  logic [`AXI_DWIDTH-1:0]       wdata;
  logic [`AXI_STRB_WIDTH-1:0]   wstrb;
  logic                         wvalid;
  logic                         wready;
  logic [1:0]                   bresp;
  logic                         bvalid;
  logic                         bready;
  logic [`AXI_AWIDTH-1:0]       araddr;
  logic [`AXI_PROT_WIDTH-1:0]   arprot;
  logic                         arvalid;
  logic                         arready;
  logic [`AXI_DWIDTH-1:0]       rdata;
  logic [1:0]                   rresp;
  logic                         rvalid;
  logic                         rready;
  logic [`AXI_DWIDTH-1:0]       tdata;
  logic [`AXI_STRB_WIDTH-1:0]   tstrb;
  logic                         tlast;
  logic                         tvalid;
  logic                         tready;

  logic [`AXI_DWIDTH-1:0]       model_q[$];      // Buffer contents with head first
  logic [`AXI_DWIDTH-1:0]       model_ctrl;
  logic [`AXI_DWIDTH-1:0]       model_scratch;
  logic [37:0]                  exp_q[$];        // Addr, resp, data per read
  logic [37:0]                  rd_exp;
  logic [31:0]                  lcg_state = 32'd42663;
  int                           chk_cnt = 0;
  int                           err_cnt = 0;
  int                           err_base;        // Errors before current test
  int                           cyc_cnt;
  int                           i;

  always #50 aclk = ~aclk; // 100 ns period

  axi_top i_dut (
    .aclk                (aclk),
    .rst                 (rst),
    .s_axi_lite_awaddr   (awaddr),
    .s_axi_lite_awprot   (awprot),
    .s_axi_lite_awvalid  (awvalid),
    .s_axi_lite_awready  (awready),
    .s_axi_lite_wdata    (wdata),
    .s_axi_lite_wstrb    (wstrb),
    .s_axi_lite_wvalid   (wvalid),
    .s_axi_lite_wready   (wready),
    .s_axi_lite_bresp    (bresp),
    .s_axi_lite_bvalid   (bvalid),
    .s_axi_lite_bready   (bready),
    .s_axi_lite_araddr   (araddr),
    .s_axi_lite_arprot   (arprot),
    .s_axi_lite_arvalid  (arvalid),
    .s_axi_lite_arready  (arready),
    .s_axi_lite_rdata    (rdata),
    .s_axi_lite_rresp    (rresp),
    .s_axi_lite_rvalid   (rvalid),
    .s_axi_lite_rready   (rready),
    .s_axi_stream_tdata  (tdata),
    .s_axi_stream_tstrb  (tstrb),
    .s_axi_stream_tlast  (tlast),
    .s_axi_stream_tvalid (tvalid),
    .s_axi_stream_tready (tready)
  );

  // LCG with 32-bit state
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Expected {resp, data} from the register map rules
  function automatic logic [33:0] exp_read(input logic [`AXI_AWIDTH-1:0] addr,
                                           input logic [31:0] ctrl,
                                           input logic [31:0] scr,
                                           input int count,
                                           input logic [31:0] head);
    logic [31:0] data;
    logic [1:0]  resp;
    data = '0;
    resp = RESP_OKAY;
    case (addr)
      REG_CTRL:    data = ctrl;
      REG_SCRATCH: data = scr;
      REG_STATUS: begin
        data[0] = (count == 0);                                 // Empty
        data[1] = (count == DEPTH);                             // Full
        data[8 +: `BUF_DEPTH_LOG2 + 1] = count[`BUF_DEPTH_LOG2:0];
      end
      REG_DATA: begin
        if (count == 0) begin
          resp = RESP_SLVERR;     // Empty read keeps data at 0
        end else begin
          data = head;
        end
      end
      default:     resp = RESP_SLVERR;
    endcase
    return {resp, data};
  endfunction

  task automatic expect_level(input logic got, input logic exp, input string what);
    chk_cnt++;
    assert (got == exp) else begin
      err_cnt++;
      $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic write_reg(input logic [`AXI_AWIDTH-1:0] addr, input logic [31:0] data);
    logic [1:0] exp_resp;
    @(posedge aclk);
    #DRIVE_DLY;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    @(negedge aclk);
    while (!(awready && wready)) @(negedge aclk);
    @(posedge aclk);                          // Accept edge
    if (addr == REG_CTRL) begin
      model_ctrl = data & ~32'h2;             // Flush bit never stored
      if (data[1]) model_q.delete();
    end else if (addr == REG_SCRATCH) begin
      model_scratch = data;
    end
    #DRIVE_DLY;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(negedge aclk);
    while (!bvalid) @(negedge aclk);
    exp_resp = (addr == REG_CTRL || addr == REG_SCRATCH) ? RESP_OKAY : RESP_SLVERR;
    chk_cnt++;
    assert (bresp == exp_resp) else begin
      err_cnt++;
      $display("** Error at %0t ns: write 0x%h bresp %0d, expected %0d",
               $time, addr, bresp, exp_resp);
    end
    @(posedge aclk);                          // Response taken
    #DRIVE_DLY;
    bready = 1'b0;
  endtask

  task automatic read_reg(input logic [`AXI_AWIDTH-1:0] addr);
    logic [31:0] head;
    @(posedge aclk);
    #DRIVE_DLY;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    @(negedge aclk);
    while (!arready) @(negedge aclk);
    head = (model_q.size() != 0) ? model_q[0] : '0;
    exp_q.push_back({addr, exp_read(addr, model_ctrl, model_scratch, model_q.size(), head)});
    @(posedge aclk);                          // Accept edge where the pop happens
    if (addr == REG_DATA && model_q.size() != 0) begin
      void'(model_q.pop_front());
    end
    #DRIVE_DLY;
    arvalid = 1'b0;
    @(negedge aclk);
    while (!rvalid) @(negedge aclk);          // Compared by the checker
    @(posedge aclk);
    #DRIVE_DLY;
    rready = 1'b0;
  endtask

  task automatic push_word(input logic [31:0] data);
    @(posedge aclk);
    #DRIVE_DLY;
    tdata  = data;
    tvalid = 1'b1;
    @(negedge aclk);
    while (!tready) @(negedge aclk);
    @(posedge aclk);                          // Beat taken
    model_q.push_back(data);
    #DRIVE_DLY;
    tvalid = 1'b0;
  endtask

  // Word held on the stream while tready must stay low
  task automatic offer_blocked(input logic [31:0] data, input int cycles);
    @(posedge aclk);
    #DRIVE_DLY;
    tdata  = data;
    tvalid = 1'b1;
    repeat (cycles) begin
      @(negedge aclk);
      expect_level(tready, 1'b0, "tready while word offered");
    end
    @(posedge aclk);
    #DRIVE_DLY;
    tvalid = 1'b0;
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %-22s %0d errors", num, name, err_cnt - err_base);
    err_base = err_cnt;
  endtask

  // Read completion compare at mid-cycle
  always @(negedge aclk) begin
    if (!rst && rvalid && rready) begin
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("read response at %0t ns with no read outstanding", $time);
      end else begin
        rd_exp = exp_q.pop_front();
        chk_cnt++;
        assert ({rresp, rdata} == rd_exp[33:0]) else begin
          err_cnt++;
          $display("** Error at %0t ns: read 0x%h got %h resp %0d, expected %h resp %0d",
                   $time, rd_exp[37:34], rdata, rresp, rd_exp[31:0], rd_exp[33:32]);
        end
      end
    end
  end

  // Run limit
  initial begin
    cyc_cnt = 0;
    while (cyc_cnt < MAX_CYCLES) begin
      @(posedge aclk);
      cyc_cnt++;
    end
    $display("timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    rst           = 1'b1;
    awaddr        = '0;
    awprot        = '0;
    awvalid       = 1'b0;
    wdata         = '0;
    wstrb         = '1;
    wvalid        = 1'b0;
    bready        = 1'b0;
    araddr        = '0;
    arprot        = '0;
    arvalid       = 1'b0;
    rready        = 1'b0;
    tdata         = '0;
    tstrb         = '1;
    tlast         = 1'b0;
    tvalid        = 1'b0;
    model_ctrl    = '0;
    model_scratch = '0;
    err_base      = 0;
    repeat (3) @(posedge aclk);
    #DRIVE_DLY;
    rst = 1'b0;

    @(negedge aclk);
    expect_level(tready, 1'b0, "tready after reset");
    expect_level(bvalid, 1'b0, "bvalid after reset");
    expect_level(rvalid, 1'b0, "rvalid after reset");
    expect_level(awready, 1'b0, "awready after reset");
    expect_level(wready, 1'b0, "wready after reset");
    expect_level(arready, 1'b0, "arready after reset");
    read_reg(REG_STATUS);
    read_reg(REG_CTRL);
    end_test(1, "reset state");

    for (i = 0; i < 6; i++) begin
      write_reg(REG_SCRATCH, next_rand());
      read_reg(REG_SCRATCH);
    end
    write_reg(REG_CTRL, next_rand() | 32'h2); // Flush set but reads back clear
    read_reg(REG_CTRL);
    end_test(2, "scratch and ctrl");

    write_reg(REG_CTRL, 32'h1);
    @(negedge aclk);
    expect_level(tready, 1'b1, "tready when enabled");
    for (i = 0; i < 6; i++) begin
      push_word(next_rand());
      read_reg(REG_STATUS);
    end
    for (i = 0; i < 6; i++) begin
      read_reg(REG_DATA);
    end
    read_reg(REG_STATUS);
    end_test(3, "stream push and pop");

    for (i = 0; i < DEPTH; i++) begin
      push_word(next_rand());
    end
    @(negedge aclk);
    expect_level(tready, 1'b0, "tready with buffer full");
    read_reg(REG_STATUS);
    offer_blocked(next_rand(), 4);
    read_reg(REG_STATUS);
    for (i = 0; i < DEPTH - 6; i++) begin
      read_reg(REG_DATA);                     // Leaves six words
    end
    end_test(4, "buffer full");

    write_reg(REG_CTRL, 32'h0);
    offer_blocked(next_rand(), 3);
    read_reg(REG_STATUS);
    write_reg(REG_CTRL, 32'h2);               // Flush only
    read_reg(REG_STATUS);
    read_reg(REG_CTRL);
    end_test(5, "disable and flush");

    read_reg(REG_DATA);                       // Empty buffer
    write_reg(REG_STATUS, next_rand());
    write_reg(REG_DATA, next_rand());
    write_reg(4'h2, next_rand());
    read_reg(4'h6);
    read_reg(REG_SCRATCH);
    read_reg(REG_CTRL);
    read_reg(REG_STATUS);
    end_test(6, "error responses");

    if (exp_q.size() != 0) begin
      err_cnt++;
      $display("%0d read responses never arrived", exp_q.size());
    end
    $display("summary: %0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+logic
logic/axi_pkg.sv
logic/stream_buffer.sv
logic/lite_write.sv
logic/lite_read.sv
logic/axi_top.sv
test/tb_axi_top.sv
